//--- include/ic_defines.svh
`ifndef IC_DEFINES_SVH
`define IC_DEFINES_SVH

// ----------------------------------------
// bus widths
// ----------------------------------------
`define IC_ADDR_W 12 // byte address
`define IC_DATA_W 32

// ----------------------------------------
// memory depth
// ----------------------------------------
`define IC_MEM_WORDS 1024 // covers the full byte address range

`endif

//--- source/axi_pkg.sv
`default_nettype none

`include "ic_defines.svh"

package axi_pkg;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // ----------------------------------------
    // channel payloads
    // ----------------------------------------
    typedef struct packed {
        logic [`IC_ADDR_W-1:0]   addr;
    } aw_chan_t;

    typedef struct packed {
        logic [`IC_DATA_W-1:0]   data;
        logic [`IC_DATA_W/8-1:0] strb; // one bit per byte lane
    } w_chan_t;

    typedef struct packed {
        logic [`IC_ADDR_W-1:0]   addr;
    } ar_chan_t;

    typedef struct packed {
        logic [1:0]              resp;
    } b_chan_t;

    typedef struct packed {
        logic [`IC_DATA_W-1:0]   data;
        logic [1:0]              resp;
    } r_chan_t;

    // ----------------------------------------
    // master side bundles
    // ----------------------------------------
    typedef struct packed {
        aw_chan_t aw;
        logic     aw_valid;
        w_chan_t  w;
        logic     w_valid;
        ar_chan_t ar;
        logic     ar_valid;
        logic     b_ready;
        logic     r_ready;
    } axi_req_t;

    typedef struct packed {
        logic     aw_ready;
        logic     w_ready;
        logic     ar_ready;
        b_chan_t  b;
        logic     b_valid;
        r_chan_t  r;
        logic     r_valid;
    } axi_rsp_t;

endpackage

`default_nettype wire

//--- source/ic_pkg.sv
`default_nettype none

package ic_pkg;

    // one-hot, m0 set after reset
    typedef struct packed {
        logic m0;
        logic m1;
    } grant_t;

    // which master currently owns a channel group
    typedef enum logic {
        OWN_M0 = 1'b0,
        OWN_M1 = 1'b1
    } arb_state_t;

endpackage

`default_nettype wire

//--- source/axi_arbiter_w.sv
`timescale 1ns/1ps
`default_nettype none

module axi_arbiter_w (
    input  wire            ACLK,
    input  wire            ARESETn,
    input  wire            m0_aw_valid,
    input  wire            m0_w_valid,
    input  wire            m0_b_ready,
    input  wire            m1_aw_valid,
    input  wire            m1_w_valid,
    input  wire            m1_b_ready,
    input  wire            aw_ready,
    input  wire            w_ready,
    input  wire            b_valid,
    output ic_pkg::grant_t wgrant
);
    import ic_pkg::*;

    arb_state_t state;
    arb_state_t next_state;
    arb_state_t other;
    logic       wr_pend;          // write accepted, B not yet taken
    logic       own_aw_valid;
    logic       own_w_valid;
    logic       own_b_ready;
    logic       other_aw_valid;
    logic       wr_hs;
    logic       b_hs;

    // ----------------------------------------
    // owner and challenger views
    // ----------------------------------------
    assign other          = (state == OWN_M1) ? OWN_M0 : OWN_M1;
    assign own_aw_valid   = (state == OWN_M1) ? m1_aw_valid : m0_aw_valid;
    assign own_w_valid    = (state == OWN_M1) ? m1_w_valid : m0_w_valid;
    assign own_b_ready    = (state == OWN_M1) ? m1_b_ready : m0_b_ready;
    assign other_aw_valid = (state == OWN_M1) ? m0_aw_valid : m1_aw_valid;

    assign wr_hs = own_aw_valid && aw_ready && own_w_valid && w_ready;
    assign b_hs  = b_valid && own_b_ready;

    always_comb begin
        next_state = state;
        if (b_hs) begin
            if (other_aw_valid) begin
                next_state = other; // rotate after a completed response
            end
        end else if (!(own_aw_valid || own_w_valid || wr_pend) && other_aw_valid) begin
            next_state = other; // idle owner yields
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state   <= OWN_M0;
            wr_pend <= 1'b0;
        end else begin
            state <= next_state;
            if (wr_hs) begin
                wr_pend <= 1'b1;
            end else if (b_hs) begin
                wr_pend <= 1'b0;
            end
        end
    end

    assign wgrant.m0 = (state == OWN_M0);
    assign wgrant.m1 = (state == OWN_M1);

endmodule

`default_nettype wire

//--- source/axi_arbiter_r.sv
`timescale 1ns/1ps
`default_nettype none

module axi_arbiter_r (
    input  wire            ACLK,
    input  wire            ARESETn,
    input  wire            m0_ar_valid,
    input  wire            m0_r_ready,
    input  wire            m1_ar_valid,
    input  wire            m1_r_ready,
    input  wire            ar_ready,
    input  wire            r_valid,
    output ic_pkg::grant_t rgrant
);
    import ic_pkg::*;

    arb_state_t state;
    arb_state_t next_state;
    logic       rd_pend;          // AR accepted, R not yet taken
    logic       own_ar_valid;
    logic       own_r_ready;
    logic       other_ar_valid;
    logic       ar_hs;
    logic       r_hs;

    assign own_ar_valid   = (state == OWN_M1) ? m1_ar_valid : m0_ar_valid;
    assign own_r_ready    = (state == OWN_M1) ? m1_r_ready : m0_r_ready;
    assign other_ar_valid = (state == OWN_M1) ? m0_ar_valid : m1_ar_valid;

    assign ar_hs = own_ar_valid && ar_ready;
    assign r_hs  = r_valid && own_r_ready;

    // same hold and rotate rule as the write side
    always_comb begin
        next_state = state;
        if ((r_hs || !(own_ar_valid || rd_pend)) && other_ar_valid) begin
            next_state = (state == OWN_M1) ? OWN_M0 : OWN_M1;
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state   <= OWN_M0;
            rd_pend <= 1'b0;
        end else begin
            state <= next_state;
            if (ar_hs) begin
                rd_pend <= 1'b1;
            end else if (r_hs) begin
                rd_pend <= 1'b0;
            end
        end
    end

    assign rgrant.m0 = (state == OWN_M0);
    assign rgrant.m1 = (state == OWN_M1);

endmodule

`default_nettype wire

//--- source/axi_chan_mux.sv
`timescale 1ns/1ps
`default_nettype none

module axi_chan_mux #(
    parameter type chan_t = logic
) (
    input  wire chan_t          in0,
    input  wire                 in0_valid,
    input  wire chan_t          in1,
    input  wire                 in1_valid,
    input  wire ic_pkg::grant_t grant,
    output chan_t               out,
    output logic                out_valid
);

    // ----------------------------------------
    // payload follows the grant, valid is gated
    // ----------------------------------------
    always_comb begin
        out       = grant.m1 ? in1 : in0;
        out_valid = (grant.m0 && in0_valid) ||
                    (grant.m1 && in1_valid); // low with no grant
    end

endmodule

`default_nettype wire

//--- source/axi_mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "ic_defines.svh"

module axi_mem_slave (
    input  wire               ACLK,
    input  wire               ARESETn,
    input  wire axi_pkg::aw_chan_t aw,
    input  wire               aw_valid,
    output logic              aw_ready,
    input  wire axi_pkg::w_chan_t  w,
    input  wire               w_valid,
    output logic              w_ready,
    output axi_pkg::b_chan_t  b,
    output logic              b_valid,
    input  wire               b_ready,
    input  wire axi_pkg::ar_chan_t ar,
    input  wire               ar_valid,
    output logic              ar_ready,
    output axi_pkg::r_chan_t  r,
    output logic              r_valid,
    input  wire               r_ready
);
    import axi_pkg::*;

    localparam int STRB_W = `IC_DATA_W / 8;
    localparam int OFS_W  = $clog2(STRB_W);          // byte offset bits
    localparam int IDX_W  = $clog2(`IC_MEM_WORDS);

    logic [`IC_DATA_W-1:0] mem [`IC_MEM_WORDS];
    logic                  wr_fire;
    logic                  rd_fire;
    logic [IDX_W-1:0]      wr_idx;
    logic [IDX_W-1:0]      rd_idx;

    assign wr_idx = aw.addr[OFS_W +: IDX_W];
    assign rd_idx = ar.addr[OFS_W +: IDX_W];

    // ----------------------------------------
    // write path
    // ----------------------------------------
    assign wr_fire  = aw_valid && w_valid && !b_valid; // AW and W taken together
    assign aw_ready = wr_fire;
    assign w_ready  = wr_fire;

    always_ff @(posedge ACLK) begin
        if (wr_fire) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (w.strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
            b.resp <= RESP_OKAY;
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            b_valid <= 1'b0;
        end else if (wr_fire) begin
            b_valid <= 1'b1;
        end else if (b_ready) begin
            b_valid <= 1'b0;   // held until accepted
        end
    end

    // ----------------------------------------
    // read path
    // ----------------------------------------
    assign ar_ready = ar_valid && !r_valid; // one read in flight
    assign rd_fire  = ar_valid && ar_ready;

    always_ff @(posedge ACLK) begin
        if (rd_fire) begin
            r.data <= mem[rd_idx];
            r.resp <= RESP_OKAY;
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            r_valid <= 1'b0;
        end else if (rd_fire) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/axi_ic_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ic_top (
    input  wire               ACLK,
    input  wire               ARESETn,
    input  wire axi_pkg::axi_req_t m0_req,
    output axi_pkg::axi_rsp_t m0_rsp,
    input  wire axi_pkg::axi_req_t m1_req,
    output axi_pkg::axi_rsp_t m1_rsp
);
    import axi_pkg::*;
    import ic_pkg::*;

    grant_t   wgrant;
    grant_t   rgrant;
    aw_chan_t s_aw;
    w_chan_t  s_w;
    ar_chan_t s_ar;
    logic     s_aw_valid;
    logic     s_w_valid;
    logic     s_ar_valid;
    logic     s_b_ready;
    logic     s_r_ready;
    axi_rsp_t s_rsp;       // everything the slave drives

    // only the granted master sees the slave side
    function automatic axi_rsp_t route_rsp(input axi_rsp_t rsp, input logic wg, input logic rg);
        axi_rsp_t res;
        res          = '0;
        res.aw_ready = wg && rsp.aw_ready;
        res.w_ready  = wg && rsp.w_ready;
        res.b_valid  = wg && rsp.b_valid;
        res.ar_ready = rg && rsp.ar_ready;
        res.r_valid  = rg && rsp.r_valid;
        if (wg) begin
            res.b = rsp.b;
        end
        if (rg) begin
            res.r = rsp.r;
        end
        return res;
    endfunction

    // ----------------------------------------
    // arbitration
    // ----------------------------------------
    axi_arbiter_w axi_arbiter_w_inst (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .m0_aw_valid (m0_req.aw_valid),
        .m0_w_valid  (m0_req.w_valid),
        .m0_b_ready  (m0_req.b_ready),
        .m1_aw_valid (m1_req.aw_valid),
        .m1_w_valid  (m1_req.w_valid),
        .m1_b_ready  (m1_req.b_ready),
        .aw_ready    (s_rsp.aw_ready),
        .w_ready     (s_rsp.w_ready),
        .b_valid     (s_rsp.b_valid),
        .wgrant      (wgrant)
    );

    axi_arbiter_r axi_arbiter_r_inst (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .m0_ar_valid (m0_req.ar_valid),
        .m0_r_ready  (m0_req.r_ready),
        .m1_ar_valid (m1_req.ar_valid),
        .m1_r_ready  (m1_req.r_ready),
        .ar_ready    (s_rsp.ar_ready),
        .r_valid     (s_rsp.r_valid),
        .rgrant      (rgrant)
    );

    // ----------------------------------------
    // request channel muxes
    // ----------------------------------------
    axi_chan_mux #(.chan_t(aw_chan_t)) aw_mux_inst (
        .in0       (m0_req.aw),
        .in0_valid (m0_req.aw_valid),
        .in1       (m1_req.aw),
        .in1_valid (m1_req.aw_valid),
        .grant     (wgrant),
        .out       (s_aw),
        .out_valid (s_aw_valid)
    );

    axi_chan_mux #(.chan_t(w_chan_t)) w_mux_inst (
        .in0       (m0_req.w),
        .in0_valid (m0_req.w_valid),
        .in1       (m1_req.w),
        .in1_valid (m1_req.w_valid),
        .grant     (wgrant),
        .out       (s_w),
        .out_valid (s_w_valid)
    );

    axi_chan_mux #(.chan_t(ar_chan_t)) ar_mux_inst (
        .in0       (m0_req.ar),
        .in0_valid (m0_req.ar_valid),
        .in1       (m1_req.ar),
        .in1_valid (m1_req.ar_valid),
        .grant     (rgrant),
        .out       (s_ar),
        .out_valid (s_ar_valid)
    );

    assign s_b_ready = (wgrant.m0 && m0_req.b_ready) || (wgrant.m1 && m1_req.b_ready);
    assign s_r_ready = (rgrant.m0 && m0_req.r_ready) || (rgrant.m1 && m1_req.r_ready);

    axi_mem_slave axi_mem_slave_inst (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .aw       (s_aw),
        .aw_valid (s_aw_valid),
        .aw_ready (s_rsp.aw_ready),
        .w        (s_w),
        .w_valid  (s_w_valid),
        .w_ready  (s_rsp.w_ready),
        .b        (s_rsp.b),
        .b_valid  (s_rsp.b_valid),
        .b_ready  (s_b_ready),
        .ar       (s_ar),
        .ar_valid (s_ar_valid),
        .ar_ready (s_rsp.ar_ready),
        .r        (s_rsp.r),
        .r_valid  (s_rsp.r_valid),
        .r_ready  (s_r_ready)
    );

    assign m0_rsp = route_rsp(s_rsp, wgrant.m0, rgrant.m0);
    assign m1_rsp = route_rsp(s_rsp, wgrant.m1, rgrant.m1);

endmodule

`default_nettype wire

//--- sim/axi_ic_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ic_defines.svh"

module axi_ic_tb;
    import axi_pkg::*;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_PAIR, OP_ROT} op_kind_t;

    typedef struct packed {
        int                    master;
        op_kind_t              kind;
        logic [`IC_ADDR_W-1:0] addr;
        logic [`IC_DATA_W-1:0] data;
        logic [3:0]            strb;
        int                    stall;  // cycles with b_ready or r_ready low
        logic [`IC_DATA_W-1:0] exp;    // read data, from the memory model
    } op_t;

    localparam int                    N_OPS          = 15;
    localparam int                    RST_CYCLES     = 5;
    localparam int                    TIMEOUT_CYCLES = N_OPS * 40 + RST_CYCLES;
    localparam logic [`IC_ADDR_W-1:0] PAIR_OFS       = 12'h100; // master 1 address in a pair
    localparam logic [`IC_ADDR_W-1:0] ROT_OFS        = 12'h200;
    localparam logic [`IC_DATA_W-1:0] ROT_XOR        = 32'h5a5a_5a5a;

    logic     ACLK;
    logic     ARESETn;
    axi_req_t req [2];
    axi_rsp_t rsp [2];

    op_t                   tbl [N_OPS];
    int                    n_ops;
    logic [`IC_DATA_W-1:0] model [`IC_MEM_WORDS];
    logic [31:0]           seed = 32'hf342;
    int                    cycle_cnt = 0;

    // per master transfer state for the running entry
    logic [`IC_ADDR_W-1:0] job_addr [2][2];
    logic [`IC_DATA_W-1:0] job_data [2][2];
    logic [3:0]            job_strb [2][2];
    int                    wr_cnt [2];
    int                    wr_sent [2];
    int                    wr_done [2];
    int                    rd_cnt [2];
    int                    rd_sent [2];
    int                    rd_done [2];
    logic [`IC_ADDR_W-1:0] rd_addr [2];
    logic [`IC_DATA_W-1:0] rd_exp [2];
    int                    b_stall [2];
    int                    r_stall [2];
    logic                  aw_hs [2];
    logic                  b_hs [2];
    logic                  ar_hs [2];
    logic                  r_hs [2];
    logic                  b_held [2];
    logic                  r_held [2];
    b_chan_t               held_b [2];
    r_chan_t               held_r [2];
    int                    b_order [$];  // master of each B handshake

    axi_ic_top axi_ic_top_inst (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .m0_req  (req[0]),
        .m0_rsp  (rsp[0]),
        .m1_req  (req[1]),
        .m1_rsp  (rsp[1])
    );

    always #5 ACLK = ~ACLK;

    always @(posedge ACLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run("Timeout: the operation table did not finish within the cycle limit");
            $fatal(1);
        end
    end

    // ----------------------------------------
    // reporting
    // ----------------------------------------
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
            $fatal(1);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            fail_run(what);
            $fatal(1);
        end
    endtask

    // ----------------------------------------
    // stimulus table and memory model
    // ----------------------------------------
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic model_write(input logic [`IC_ADDR_W-1:0] addr,
                               input logic [`IC_DATA_W-1:0] data, input logic [3:0] strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                model[addr[`IC_ADDR_W-1:2]][8*b +: 8] = data[8*b +: 8]; // byte lanes by strobe
            end
        end
    endtask

    task automatic add_op(input int master, input op_kind_t kind,
                          input logic [`IC_ADDR_W-1:0] addr, input logic [`IC_DATA_W-1:0] data,
                          input logic [3:0] strb, input int stall);
        op_t o;
        o.master = master;
        o.kind   = kind;
        o.addr   = addr;
        o.data   = data;
        o.strb   = strb;
        o.stall  = stall;
        o.exp    = '0;
        case (kind)
            OP_WR: model_write(addr, data, strb);
            OP_RD: o.exp = model[addr[`IC_ADDR_W-1:2]];
            OP_PAIR: begin
                model_write(addr, data, 4'hf);
                model_write(addr + PAIR_OFS, ~data, 4'hf);
            end
            default: begin
                model_write(addr, data, 4'hf);
                model_write(addr + 12'h004, data ^ ROT_XOR, 4'hf);
                model_write(addr + ROT_OFS, ~data, 4'hf);
            end
        endcase
        tbl[n_ops] = o;
        n_ops++;
    endtask

    // pair and rotation entries follow a master 0 write, so master 0 owns the write grant
    task automatic build_table();
        n_ops = 0;
        add_op(0, OP_WR,   12'h010, next_rand(),   4'hf,    0);
        add_op(0, OP_RD,   12'h010, '0,            4'h0,    0);
        add_op(1, OP_RD,   12'h010, '0,            4'h0,    0); // other master reads back
        add_op(0, OP_PAIR, 12'h040, next_rand(),   4'hf,    2);
        add_op(1, OP_RD,   12'h040, '0,            4'h0,    0);
        add_op(0, OP_RD,   12'h140, '0,            4'h0,    1);
        add_op(1, OP_WR,   12'h020, next_rand(),   4'hf,    2);
        add_op(1, OP_WR,   12'h020, 32'haabb_ccdd, 4'b0101, 0); // partial strobes
        add_op(0, OP_RD,   12'h020, '0,            4'h0,    3);
        add_op(0, OP_WR,   12'hffc, next_rand(),   4'hf,    1); // top word
        add_op(1, OP_RD,   12'hffc, '0,            4'h0,    1);
        add_op(0, OP_ROT,  12'h080, next_rand(),   4'hf,    0);
        add_op(1, OP_RD,   12'h084, '0,            4'h0,    0);
        add_op(0, OP_RD,   12'h280, '0,            4'h0,    2);
        add_op(1, OP_RD,   12'h080, '0,            4'h0,    0);
    endtask

    // ----------------------------------------
    // master drivers, one cycle at a time
    // ----------------------------------------
    task automatic clear_op_state();
        for (int m = 0; m < 2; m++) begin
            wr_cnt[m]  = 0;
            wr_sent[m] = 0;
            wr_done[m] = 0;
            rd_cnt[m]  = 0;
            rd_sent[m] = 0;
            rd_done[m] = 0;
            b_stall[m] = 0;
            r_stall[m] = 0;
            aw_hs[m]   = 1'b0;
            b_hs[m]    = 1'b0;
            ar_hs[m]   = 1'b0;
            r_hs[m]    = 1'b0;
            b_held[m]  = 1'b0;
            r_held[m]  = 1'b0;
        end
        b_order.delete();
    endtask

    task automatic add_job(input int m, input logic [`IC_ADDR_W-1:0] addr,
                           input logic [`IC_DATA_W-1:0] data, input logic [3:0] strb);
        job_addr[m][wr_cnt[m]] = addr;
        job_data[m][wr_cnt[m]] = data;
        job_strb[m][wr_cnt[m]] = strb;
        wr_cnt[m]++;
    endtask

    task automatic drive_master(input int m);
        req[m].aw_valid = (wr_sent[m] < wr_cnt[m]); // next write follows at once
        req[m].w_valid  = (wr_sent[m] < wr_cnt[m]);
        if (wr_sent[m] < wr_cnt[m]) begin
            req[m].aw.addr = job_addr[m][wr_sent[m]];
            req[m].w.data  = job_data[m][wr_sent[m]];
            req[m].w.strb  = job_strb[m][wr_sent[m]];
        end
        req[m].b_ready  = (b_stall[m] == 0);
        req[m].ar_valid = (rd_sent[m] < rd_cnt[m]);
        if (rd_sent[m] < rd_cnt[m]) begin
            req[m].ar.addr = rd_addr[m];
        end
        req[m].r_ready  = (r_stall[m] == 0);
    endtask

    task automatic sample_master(input int m);
        int o;
        o = 1 - m;
        aw_hs[m] = req[m].aw_valid && rsp[m].aw_ready;
        b_hs[m]  = rsp[m].b_valid && req[m].b_ready;
        ar_hs[m] = req[m].ar_valid && rsp[m].ar_ready;
        r_hs[m]  = rsp[m].r_valid && req[m].r_ready;
        check_true(!rsp[m].aw_ready || req[m].aw_valid,
                   $sformatf("Master %0d saw aw_ready without a write request", m));
        check_true(rsp[m].w_ready == rsp[m].aw_ready,
                   $sformatf("Master %0d saw AW and W accepted apart", m));
        check_true(!rsp[m].ar_ready || req[m].ar_valid,
                   $sformatf("Master %0d saw ar_ready without a read request", m));
        check_true(!rsp[m].b_valid || wr_sent[m] > wr_done[m],
                   $sformatf("Master %0d saw b_valid with no write outstanding", m));
        check_true(!rsp[m].r_valid || rd_sent[m] > rd_done[m],
                   $sformatf("Master %0d saw r_valid with no read outstanding", m));
        if (rsp[m].b_valid) begin
            if (b_held[m]) begin
                check_val($sformatf("m%0d_rsp.b.resp", m), 32'(rsp[m].b.resp), 32'(held_b[m].resp));
            end
            b_held[m] = !req[m].b_ready;
            held_b[m] = rsp[m].b;
            if (!req[m].b_ready) begin
                b_stall[m]--;
                check_true(!rsp[o].aw_ready,
                           $sformatf("Master %0d got aw_ready while a B response was held", o));
            end else begin
                check_val($sformatf("m%0d_rsp.b.resp", m), 32'(rsp[m].b.resp), 32'(RESP_OKAY));
            end
        end else begin
            b_held[m] = 1'b0;
        end
        if (rsp[m].r_valid) begin
            if (r_held[m]) begin
                check_val($sformatf("m%0d_rsp.r.data", m), rsp[m].r.data, held_r[m].data);
            end
            r_held[m] = !req[m].r_ready;
            held_r[m] = rsp[m].r;
            if (!req[m].r_ready) begin
                r_stall[m]--;
                check_true(!rsp[o].ar_ready,
                           $sformatf("Master %0d got ar_ready while an R response was held", o));
            end else begin
                check_val($sformatf("m%0d_rsp.r.data", m), rsp[m].r.data, rd_exp[m]);
                check_val($sformatf("m%0d_rsp.r.resp", m), 32'(rsp[m].r.resp), 32'(RESP_OKAY));
            end
        end else begin
            r_held[m] = 1'b0;
        end
    endtask

    task automatic step_cycle(output logic fin);
        @(negedge ACLK);
        fin = 1'b1;
        for (int m = 0; m < 2; m++) begin
            if (aw_hs[m]) wr_sent[m]++;  // handshakes seen at the last rising edge
            if (b_hs[m]) begin
                wr_done[m]++;
                b_order.push_back(m);
            end
            if (ar_hs[m]) rd_sent[m]++;
            if (r_hs[m]) rd_done[m]++;
            if (wr_done[m] < wr_cnt[m] || rd_done[m] < rd_cnt[m]) fin = 1'b0;
            drive_master(m);
        end
        #1;
        for (int m = 0; m < 2; m++) begin
            sample_master(m);
        end
    endtask

    task automatic run_op(input int i);
        op_t  o;
        int   m;
        logic fin;
        int   exp_order [$];
        o = tbl[i];
        m = o.master;
        clear_op_state();
        case (o.kind)
            OP_WR: begin
                add_job(m, o.addr, o.data, o.strb);
                b_stall[m] = o.stall;
                exp_order.push_back(m);
            end
            OP_RD: begin
                rd_cnt[m]  = 1;
                rd_addr[m] = o.addr;
                rd_exp[m]  = o.exp;
                r_stall[m] = o.stall;
                if (o.stall > 0) begin
                    rd_cnt[1-m]  = 1;  // other master waits behind the held R
                    rd_addr[1-m] = o.addr;
                    rd_exp[1-m]  = o.exp;
                end
            end
            OP_PAIR: begin
                add_job(0, o.addr, o.data, 4'hf);
                add_job(1, o.addr + PAIR_OFS, ~o.data, 4'hf);
                b_stall[m] = o.stall;
                exp_order.push_back(0);  // master 0 owns the grant first
                exp_order.push_back(1);
            end
            default: begin
                add_job(0, o.addr, o.data, 4'hf);
                add_job(0, o.addr + 12'h004, o.data ^ ROT_XOR, 4'hf);
                add_job(1, o.addr + ROT_OFS, ~o.data, 4'hf);
                exp_order.push_back(0);
                exp_order.push_back(1);  // slots in between the two master 0 writes
                exp_order.push_back(0);
            end
        endcase
        fin = 1'b0;
        while (!fin) step_cycle(fin);
        check_val($sformatf("entry %0d B response count", i), b_order.size(), exp_order.size());
        for (int k = 0; k < exp_order.size(); k++) begin
            check_val($sformatf("entry %0d B response %0d master", i, k),
                      b_order[k], exp_order[k]);
        end
    endtask

    initial begin
        logic fin;
        ACLK    = 1'b0;
        ARESETn = 1'b0;
        req[0]  = '0;
        req[1]  = '0;
        clear_op_state();
        build_table();
        repeat (RST_CYCLES) @(negedge ACLK);
        ARESETn = 1'b1;
        repeat (3) step_cycle(fin);  // both ports stay quiet while idle
        for (int i = 0; i < n_ops; i++) begin
            run_op(i);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- axi_ic_top.f
+incdir+include
source/axi_pkg.sv
source/ic_pkg.sv
source/axi_arbiter_w.sv
source/axi_arbiter_r.sv
source/axi_chan_mux.sv
source/axi_mem_slave.sv
source/axi_ic_top.sv
sim/axi_ic_tb.sv

//--- Makefile
TOP = axi_ic_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f axi_ic_top.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
